/* sources.f */
common/wb_pkg.sv
common/peri_pkg.sv
source/wb_bridge.sv
source/peri_decoder.sv
irc/irc_core.sv
timer/timer_core.sv
sram/sram_bank.sv
source/peri_top.sv
test/peri_assertions.sv
test/tb_peri_top.sv

/* Makefile */
# verilator build and run of the peripheral subsystem testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_peri_top
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = TEST PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_peri_top.sv */
// --------------------
//  testbench for peri_top
//  clock, reset, lfsr, bus tasks
//  directed tests with summary
// --------------------

`timescale 1ns/1ps

module tb_peri_top;

	localparam int CLK_HALF       = 20;
	localparam int RESET_CYCLES   = 4;
	localparam int SRAM_WORDS     = peri_pkg::SRAM_WORDS_DEFAULT;
	localparam int SRAM_IDX_BITS  = $clog2(SRAM_WORDS);
	localparam int SRAM_FILL      = 16;
	localparam int PICK_BITS      = $clog2(SRAM_FILL);
	localparam int UNMAPPED_TRIES = 8;
	localparam int TIMER_COMPARE  = 24;
	localparam int POLL_MAX       = 32;
	localparam int IRQ_WAIT_MAX   = 16;

	// run length, accesses of all tests plus irq waits
	localparam int ACCESS_CYCLES  = 6;
	localparam int ACCESS_COUNT   = 3 * SRAM_FILL + 2 * UNMAPPED_TRIES + SRAM_FILL
		+ POLL_MAX + 32;
	localparam int WAIT_CYCLES    = 4 * IRQ_WAIT_MAX + RESET_CYCLES + 4;
	localparam int TIMEOUT_CYCLES = 20 * (ACCESS_COUNT * ACCESS_CYCLES + WAIT_CYCLES);

	logic				clk;
	logic				arst_n_i;
	wb_pkg::wb_req_t	cpu_req;
	wb_pkg::wb_rsp_t	cpu_rsp;
	logic	[1:0]		irq_ext;
	logic				cpu_irq;
	logic				cpu_irq_ack;

	logic	[15:0]		lfsr_state;
	int					errors;
	int					tests_run;
	int					tests_failed;
	int					cycle_cnt;

	// sram reference
	logic	[31:0]		model_mem [SRAM_WORDS];
	int					used_idx [SRAM_FILL];

	peri_top DUT
		(
			.clk			(clk),
			.arst_n_i		(arst_n_i),
			.cpu_req_i		(cpu_req),
			.cpu_rsp_o		(cpu_rsp),
			.irq_ext_i		(irq_ext),
			.cpu_irq_o		(cpu_irq),
			.cpu_irq_ack_i	(cpu_irq_ack)
		);

	initial
	begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// --------------------
	//  helpers
	// --------------------

	// 16 bit galois lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] sel);
		logic	[31:0]	mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	function automatic logic [31:0] periph_addr(input logic [7:0] base, input logic [1:0] ofs);
		return {base, 20'h0, ofs, 2'b00};
	endfunction

	function automatic logic [31:0] sram_addr(input int idx);
		return {peri_pkg::PERI_SRAM_BASE, 24'(idx * 4)};
	endfunction

	// one classic cycle, stb held until ack
	task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdat,
		input logic [3:0] sel, output logic [31:0] rdat);
		wb_pkg::wb_req_t	req;
		req.adr = addr[31:2];
		req.dat = wdat;
		req.we  = we;
		req.sel = sel;
		req.stb = 1'b1;
		@(posedge clk);
		cpu_req <= req;
		do
		begin
			@(negedge clk);
		end
		while (!cpu_rsp.ack);
		rdat = cpu_rsp.dat;
		@(posedge clk);
		cpu_req.stb <= 1'b0;
	endtask

	task automatic wb_write(input logic [31:0] addr, input logic [31:0] wdat,
		input logic [3:0] sel);
		logic	[31:0]	unused;
		bus_access(1'b1, addr, wdat, sel, unused);
	endtask

	task automatic wb_read(input logic [31:0] addr, output logic [31:0] rdat);
		bus_access(1'b0, addr, 32'h0, 4'hf, rdat);
	endtask

	task automatic wait_irq(input int max_cycles, output logic seen);
		seen = 1'b0;
		for (int i = 0; i < max_cycles && !seen; i++)
		begin
			@(negedge clk);
			seen = cpu_irq;
		end
	endtask

	// --------------------
	//  compare tasks
	// --------------------

	task automatic check_rsp(input string name, input logic [wb_pkg::WB_DAT_WIDTH-1:0] exp_dat,
		input logic [wb_pkg::WB_DAT_WIDTH-1:0] act_dat);
		if (act_dat !== exp_dat)
		begin
			$display("** Error %s: expected %h, actual %h", name, exp_dat, act_dat);
			errors++;
		end
	endtask

	task automatic check_irq(input string name, input peri_pkg::irc_factor_t exp_id,
		input peri_pkg::irc_factor_t act_id, input logic exp_irq, input logic act_irq);
		if (act_id !== exp_id)
		begin
			$display("** Error %s factor id: expected %0d, actual %0d", name, exp_id, act_id);
			errors++;
		end
		if (act_irq !== exp_irq)
		begin
			$display("** Error %s cpu irq: expected %b, actual %b", name, exp_irq, act_irq);
			errors++;
		end
	endtask

	// factor id register, then the irq line
	task automatic check_irq_state(input string name, input peri_pkg::irc_factor_t exp_id,
		input logic exp_irq);
		logic	[31:0]	r;
		wb_read(periph_addr(peri_pkg::PERI_IRC_BASE, peri_pkg::IRC_REG_FACTOR_ID), r);
		@(negedge clk);
		check_irq(name, exp_id, peri_pkg::irc_factor_t'(r[2:0]), exp_irq, cpu_irq);
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start)
		begin
			$display("%-10s ok", name);
		end
		else
		begin
			tests_failed++;
			$display("%-10s failed with %0d errors", name, errors - err_start);
		end
	endtask

	// --------------------
	//  directed tests
	// --------------------

	task automatic test_sram();
		int				err_start;
		int				idx;
		logic	[31:0]	r;
		logic	[31:0]	d;
		logic	[31:0]	s;
		err_start = errors;
		for (int i = 0; i < SRAM_FILL; i++)
		begin
			take_bits(SRAM_IDX_BITS, r);
			take_bits(32, d);
			used_idx[i] = int'(r[SRAM_IDX_BITS-1:0]);
			model_mem[used_idx[i]] = d;
			wb_write(sram_addr(used_idx[i]), d, 4'hf);
		end
		// partial writes onto words already known
		for (int i = 0; i < SRAM_FILL; i++)
		begin
			take_bits(PICK_BITS, r);
			take_bits(4, s);
			take_bits(32, d);
			idx = used_idx[r[PICK_BITS-1:0]];
			model_mem[idx] = merge_bytes(model_mem[idx], d, s[3:0]);
			wb_write(sram_addr(idx), d, s[3:0]);
		end
		for (int i = 0; i < SRAM_FILL; i++)
		begin
			wb_read(sram_addr(used_idx[i]), r);
			check_rsp("sram read", model_mem[used_idx[i]], r);
		end
		end_test("sram", err_start);
	endtask

	task automatic test_unmapped();
		int				err_start;
		logic	[31:0]	top;
		logic	[31:0]	low;
		logic	[31:0]	d;
		logic	[31:0]	r;
		err_start = errors;
		for (int i = 0; i < UNMAPPED_TRIES; i++)
		begin
			take_bits(8, top);
			take_bits(24, low);
			if (top[7:0] == peri_pkg::PERI_IRC_BASE || top[7:0] == peri_pkg::PERI_TIMER_BASE
				|| top[7:0] == peri_pkg::PERI_SRAM_BASE)
			begin
				top[7:0] = top[7:0] ^ 8'h80;
			end
			wb_read({top[7:0], low[23:0]}, r);
			check_rsp("unmapped read", 32'h0, r);
			// low bits alias a live sram word
			take_bits(32, d);
			wb_write({top[7:0], 24'(used_idx[i] * 4)}, d, 4'hf);
		end
		for (int i = 0; i < SRAM_FILL; i++)
		begin
			wb_read(sram_addr(used_idx[i]), r);
			check_rsp("unmapped sram", model_mem[used_idx[i]], r);
		end
		end_test("unmapped", err_start);
	endtask

	task automatic test_timer();
		int				err_start;
		int				reads;
		logic			seen;
		logic	[31:0]	r;
		err_start = errors;
		reads = 0;
		seen  = 1'b0;
		wb_write(periph_addr(peri_pkg::PERI_IRC_BASE, peri_pkg::IRC_REG_ENABLE), 32'h1, 4'hf);
		wb_write(periph_addr(peri_pkg::PERI_TIMER_BASE, peri_pkg::TIMER_REG_COMPARE),
			32'(TIMER_COMPARE), 4'hf);
		wb_write(periph_addr(peri_pkg::PERI_TIMER_BASE, peri_pkg::TIMER_REG_CONTROL),
			32'h1, 4'hf);
		while (!seen && reads < POLL_MAX)
		begin
			wb_read(periph_addr(peri_pkg::PERI_TIMER_BASE, peri_pkg::TIMER_REG_COUNTER), r);
			reads++;
			if (r > 32'(TIMER_COMPARE))
			begin
				$display("** Error timer counter: expected at most %0d, actual %0d",
					TIMER_COMPARE, r);
				errors++;
			end
			@(negedge clk);
			seen = cpu_irq;
		end
		if (!seen)
		begin
			$display("timer: cpu irq never rose within %0d counter reads", POLL_MAX);
			errors++;
		end
		else
		begin
			check_irq_state("timer irq", 3'd0, 1'b1);
		end
		// stop the timer before clearing its pending bit
		wb_write(periph_addr(peri_pkg::PERI_TIMER_BASE, peri_pkg::TIMER_REG_CONTROL),
			32'h0, 4'hf);
		wb_write(periph_addr(peri_pkg::PERI_IRC_BASE, peri_pkg::IRC_REG_PENDING), 32'h7, 4'hf);
		wb_write(periph_addr(peri_pkg::PERI_IRC_BASE, peri_pkg::IRC_REG_ENABLE), 32'h0, 4'hf);
		check_irq_state("timer idle", 3'd3, 1'b0);
		end_test("timer", err_start);
	endtask

	task automatic test_mask();
		int				err_start;
		logic			seen;
		logic	[31:0]	r;
		err_start = errors;
		wb_write(periph_addr(peri_pkg::PERI_IRC_BASE, peri_pkg::IRC_REG_ENABLE), 32'h4, 4'hf);
		@(posedge clk);
		irq_ext <= 2'b11;
		wait_irq(IRQ_WAIT_MAX, seen);
		if (!seen)
		begin
			$display("mask: cpu irq did not rise with factor 2 pending and enabled");
			errors++;
		end
		check_irq_state("mask bit 2", 3'd2, 1'b1);
		wb_write(periph_addr(peri_pkg::PERI_IRC_BASE, peri_pkg::IRC_REG_ENABLE), 32'h6, 4'hf);
		check_irq_state("mask bit 1", 3'd1, 1'b1);
		wb_write(periph_addr(peri_pkg::PERI_IRC_BASE, peri_pkg::IRC_REG_ENABLE), 32'h0, 4'hf);
		check_irq_state("mask zero", 3'd3, 1'b0);
		wait_irq(IRQ_WAIT_MAX, seen);
		if (seen)
		begin
			$display("mask: cpu irq rose with the mask at zero");
			errors++;
		end
		wb_read(periph_addr(peri_pkg::PERI_IRC_BASE, peri_pkg::IRC_REG_PENDING), r);
		check_rsp("mask pending", 32'h6, r);
		@(posedge clk);
		irq_ext <= 2'b00;
		end_test("mask", err_start);
	endtask

	task automatic test_clear();
		int				err_start;
		logic			seen;
		logic	[31:0]	r;
		err_start = errors;
		// factors 1 and 2 still pending from the mask test
		wb_write(periph_addr(peri_pkg::PERI_IRC_BASE, peri_pkg::IRC_REG_ENABLE), 32'h6, 4'hf);
		wait_irq(IRQ_WAIT_MAX, seen);
		if (!seen)
		begin
			$display("clear: cpu irq did not rise with factors 1 and 2 pending");
			errors++;
		end
		check_irq_state("clear start", 3'd1, 1'b1);
		@(posedge clk);
		cpu_irq_ack <= 1'b1;
		@(posedge clk);
		cpu_irq_ack <= 1'b0;
		check_irq_state("clear ack", 3'd2, 1'b1);
		wb_read(periph_addr(peri_pkg::PERI_IRC_BASE, peri_pkg::IRC_REG_PENDING), r);
		check_rsp("clear pending", 32'h4, r);
		wb_write(periph_addr(peri_pkg::PERI_IRC_BASE, peri_pkg::IRC_REG_PENDING), 32'h7, 4'hf);
		check_irq_state("clear w1c", 3'd3, 1'b0);
		wb_read(periph_addr(peri_pkg::PERI_IRC_BASE, peri_pkg::IRC_REG_PENDING), r);
		check_rsp("clear empty", 32'h0, r);
		wb_write(periph_addr(peri_pkg::PERI_IRC_BASE, peri_pkg::IRC_REG_ENABLE), 32'h0, 4'hf);
		end_test("clear", err_start);
	endtask

	// --------------------
	//  run control
	// --------------------

	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, a bus access or interrupt never completed",
			TIMEOUT_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		arst_n_i     = 1'b0;
		cpu_req      = '0;
		irq_ext      = 2'b00;
		cpu_irq_ack  = 1'b0;
		lfsr_state   = 16'd4;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n_i <= 1'b1;

		test_sram();
		test_unmapped();
		test_timer();
		test_mask();
		test_clear();

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
		begin
			$display("TEST PASS");
		end
		else
		begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* test/peri_assertions.sv */
// --------------------
//  wishbone handshake checks
//  irq level during reset
//  bind statements
// --------------------

`timescale 1ns/1ps

module peri_assertions
	(
		input	logic				clk,
		input	logic				arst_n_i,
		input	wb_pkg::wb_req_t	req_i,
		input	wb_pkg::wb_rsp_t	rsp_i,
		input	logic				irq_i
	);

	// master keeps stb until ack
	stb_held : assert property (@(posedge clk) disable iff (!arst_n_i)
		(req_i.stb && !rsp_i.ack) |=> req_i.stb)
		else $error("stb dropped before ack");

	// request fields do not move while waiting
	fields_stable : assert property (@(posedge clk) disable iff (!arst_n_i)
		(req_i.stb && !rsp_i.ack) |=> $stable({req_i.adr, req_i.dat, req_i.we, req_i.sel}))
		else $error("request fields changed while waiting for ack");

	ack_needs_stb : assert property (@(posedge clk) disable iff (!arst_n_i)
		rsp_i.ack |-> req_i.stb)
		else $error("ack seen without stb");

	irq_low_in_reset : assert property (@(posedge clk)
		!arst_n_i |-> !irq_i)
		else $error("cpu irq high during reset");

endmodule

// peripheral side of the bridge, no irq there
bind wb_bridge peri_assertions u_bus_chk
	(
		.clk		(clk),
		.arst_n_i	(arst_n_i),
		.req_i		(out_req_o),
		.rsp_i		(out_rsp_i),
		.irq_i		(1'b0)
	);

bind peri_top peri_assertions u_cpu_chk
	(
		.clk		(clk),
		.arst_n_i	(arst_n_i),
		.req_i		(cpu_req_i),
		.rsp_i		(cpu_rsp_o),
		.irq_i		(cpu_irq_o)
	);

/* source/peri_top.sv */
// --------------------
//  peripheral subsystem top
//  bridge, decoder, irc, timer, sram
// --------------------

`timescale 1ns/1ps

module peri_top
	(
		input	logic				clk,
		input	logic				arst_n_i,

		// cpu side bus
		input	wb_pkg::wb_req_t	cpu_req_i,
		output	wb_pkg::wb_rsp_t	cpu_rsp_o,

		// interrupts
		input	logic	[1:0]		irq_ext_i,
		output	logic				cpu_irq_o,
		input	logic				cpu_irq_ack_i
	);

	// peripheral bus after the bridge
	wb_pkg::wb_req_t	peri_req;
	wb_pkg::wb_rsp_t	peri_rsp;

	// per slave buses
	wb_pkg::wb_req_t	irc_req;
	wb_pkg::wb_rsp_t	irc_rsp;
	wb_pkg::wb_req_t	timer_req;
	wb_pkg::wb_rsp_t	timer_rsp;
	wb_pkg::wb_req_t	sram_req;
	wb_pkg::wb_rsp_t	sram_rsp;

	logic				timer_irq;

	wb_bridge i_wb_bridge
		(
			.clk			(clk),
			.arst_n_i		(arst_n_i),
			.in_req_i		(cpu_req_i),
			.in_rsp_o		(cpu_rsp_o),
			.out_req_o		(peri_req),
			.out_rsp_i		(peri_rsp)
		);

	peri_decoder i_peri_decoder
		(
			.req_i			(peri_req),
			.rsp_o			(peri_rsp),
			.irc_req_o		(irc_req),
			.irc_rsp_i		(irc_rsp),
			.timer_req_o	(timer_req),
			.timer_rsp_i	(timer_rsp),
			.sram_req_o		(sram_req),
			.sram_rsp_i		(sram_rsp)
		);

	// timer is factor 0, external lines above it
	irc_core i_irc_core
		(
			.clk			(clk),
			.arst_n_i		(arst_n_i),
			.factor_i		({irq_ext_i, timer_irq}),
			.cpu_irq_o		(cpu_irq_o),
			.cpu_irq_ack_i	(cpu_irq_ack_i),
			.req_i			(irc_req),
			.rsp_o			(irc_rsp)
		);

	timer_core i_timer_core
		(
			.clk			(clk),
			.arst_n_i		(arst_n_i),
			.irq_o			(timer_irq),
			.req_i			(timer_req),
			.rsp_o			(timer_rsp)
		);

	sram_bank i_sram_bank
		(
			.clk			(clk),
			.arst_n_i		(arst_n_i),
			.req_i			(sram_req),
			.rsp_o			(sram_rsp)
		);

endmodule

/* sram/sram_bank.sv */
// --------------------
//  internal sram
//  byte writable, registered read
// --------------------

`timescale 1ns/1ps

module sram_bank
	#(
		parameter int WORDS = peri_pkg::SRAM_WORDS_DEFAULT
	)
	(
		input	logic				clk,
		input	logic				arst_n_i,

		input	wb_pkg::wb_req_t	req_i,
		output	wb_pkg::wb_rsp_t	rsp_o
	);

	localparam int IDX_WIDTH = (WORDS > 1) ? $clog2(WORDS) : 1;

	logic	[wb_pkg::WB_DAT_WIDTH-1:0]	mem [WORDS];
	logic	[IDX_WIDTH-1:0]				idx;
	logic								in_range;
	logic								bus_cyc;
	logic								ack_q;
	logic	[wb_pkg::WB_DAT_WIDTH-1:0]	rd_dat_q;

	assign idx      = req_i.adr[IDX_WIDTH-1:0];
	// depth need not be a power of two
	assign in_range = (int'(idx) < WORDS);
	assign bus_cyc  = req_i.stb & ~ack_q;

	always_ff @(posedge clk)
	begin
		if (bus_cyc)
		begin
			if (req_i.we && in_range)
			begin
				mem[idx] <= wb_pkg::wb_byte_merge(mem[idx], req_i.dat, req_i.sel);
			end
			rd_dat_q <= in_range ? mem[idx] : '0;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			ack_q <= 1'b0;
		end
		else
		begin
			ack_q <= bus_cyc;
		end
	end

	assign rsp_o = '{dat: rd_dat_q, ack: ack_q};

endmodule

/* timer/timer_core.sv */
// --------------------
//  interval timer
//  counter with compare reload, irq pulse
// --------------------

`timescale 1ns/1ps

module timer_core
	(
		input	logic				clk,
		input	logic				arst_n_i,

		output	logic				irq_o,

		input	wb_pkg::wb_req_t	req_i,
		output	wb_pkg::wb_rsp_t	rsp_o
	);

	logic										enable_q;
	logic	[wb_pkg::WB_DAT_WIDTH-1:0]			compare_q;
	logic	[wb_pkg::WB_DAT_WIDTH-1:0]			counter_q;
	logic										match;
	logic										irq_q;
	logic	[peri_pkg::REG_OFS_WIDTH-1:0]		reg_ofs;
	logic										bus_cyc;
	logic										wr_en;
	logic										ack_q;
	logic	[wb_pkg::WB_DAT_WIDTH-1:0]			rd_dat;
	logic	[wb_pkg::WB_DAT_WIDTH-1:0]			rd_dat_q;

	assign bus_cyc = req_i.stb & ~ack_q;
	assign wr_en   = bus_cyc & req_i.we;
	assign reg_ofs = req_i.adr[peri_pkg::REG_OFS_WIDTH-1:0];

	// reload point
	assign match = enable_q & (counter_q == compare_q);

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			enable_q  <= 1'b0;
			compare_q <= '0;
			counter_q <= '0;
			irq_q     <= 1'b0;
			ack_q     <= 1'b0;
		end
		else
		begin
			if (wr_en && reg_ofs == peri_pkg::TIMER_REG_CONTROL && req_i.sel[0])
			begin
				enable_q <= req_i.dat[0];
			end
			if (wr_en && reg_ofs == peri_pkg::TIMER_REG_COMPARE)
			begin
				compare_q <= wb_pkg::wb_byte_merge(compare_q, req_i.dat, req_i.sel);
			end

			if (match)
			begin
				counter_q <= '0;
			end
			else if (enable_q)
			begin
				counter_q <= counter_q + 1'b1;
			end

			irq_q <= match;
			ack_q <= bus_cyc;
		end
	end

	// --------------------
	//  register read
	// --------------------

	always_comb
	begin
		rd_dat = '0;
		case (reg_ofs)
			peri_pkg::TIMER_REG_CONTROL:	rd_dat[0] = enable_q;
			peri_pkg::TIMER_REG_COMPARE:	rd_dat = compare_q;
			peri_pkg::TIMER_REG_COUNTER:	rd_dat = counter_q;
			default:						rd_dat = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (bus_cyc)
		begin
			rd_dat_q <= rd_dat;
		end
	end

	assign rsp_o = '{dat: rd_dat_q, ack: ack_q};
	assign irq_o = irq_q;

endmodule

/* irc/irc_core.sv */
// --------------------
//  interrupt controller
//  pending, mask, fixed priority
//  cpu request and acknowledge
// --------------------

`timescale 1ns/1ps

module irc_core
	(
		input	logic					clk,
		input	logic					arst_n_i,

		input	peri_pkg::irc_factor_t	factor_i,

		output	logic					cpu_irq_o,
		input	logic					cpu_irq_ack_i,

		input	wb_pkg::wb_req_t		req_i,
		output	wb_pkg::wb_rsp_t		rsp_o
	);

	peri_pkg::irc_factor_t						factor_q;
	peri_pkg::irc_factor_t						enable_q;
	peri_pkg::irc_factor_t						pending_q;
	peri_pkg::irc_factor_t						win_oh;
	peri_pkg::irc_factor_t						clr;
	peri_pkg::irc_id_t							factor_id;
	logic	[peri_pkg::REG_OFS_WIDTH-1:0]		reg_ofs;
	logic										bus_cyc;
	logic										wr_en;
	logic										ack_q;
	logic										irq_q;
	logic	[wb_pkg::WB_DAT_WIDTH-1:0]			rd_dat;
	logic	[wb_pkg::WB_DAT_WIDTH-1:0]			rd_dat_q;

	// first cycle of a strobe
	assign bus_cyc = req_i.stb & ~ack_q;
	assign wr_en   = bus_cyc & req_i.we & req_i.sel[0];
	assign reg_ofs = req_i.adr[peri_pkg::REG_OFS_WIDTH-1:0];

	// lowest enabled pending index wins
	always_comb
	begin
		factor_id = peri_pkg::IRC_FACTOR_ID_NONE;
		win_oh    = '0;
		for (int i = peri_pkg::IRC_FACTOR_NUM - 1; i >= 0; i--)
		begin
			if (pending_q[i] & enable_q[i])
			begin
				factor_id = peri_pkg::irc_id_t'(i);
				win_oh    = '0;
				win_oh[i] = 1'b1;
			end
		end
	end

	// cpu ack drops the winner, bus write-one drops the written bits
	always_comb
	begin
		clr = cpu_irq_ack_i ? win_oh : '0;
		if (wr_en && reg_ofs == peri_pkg::IRC_REG_PENDING)
		begin
			clr = clr | req_i.dat[peri_pkg::IRC_FACTOR_NUM-1:0];
		end
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			factor_q  <= '0;
			enable_q  <= '0;
			pending_q <= '0;
			ack_q     <= 1'b0;
			irq_q     <= 1'b0;
		end
		else
		begin
			factor_q  <= factor_i;
			// a fresh edge survives a clear in the same cycle
			pending_q <= (pending_q & ~clr) | (factor_i & ~factor_q);
			if (wr_en && reg_ofs == peri_pkg::IRC_REG_ENABLE)
			begin
				enable_q <= req_i.dat[peri_pkg::IRC_FACTOR_NUM-1:0];
			end
			ack_q <= bus_cyc;
			irq_q <= |(pending_q & enable_q);
		end
	end

	// --------------------
	//  register read
	// --------------------

	always_comb
	begin
		rd_dat = '0;
		case (reg_ofs)
			peri_pkg::IRC_REG_ENABLE:		rd_dat[peri_pkg::IRC_FACTOR_NUM-1:0] = enable_q;
			peri_pkg::IRC_REG_PENDING:		rd_dat[peri_pkg::IRC_FACTOR_NUM-1:0] = pending_q;
			peri_pkg::IRC_REG_FACTOR_ID:	rd_dat[peri_pkg::IRC_FACTOR_ID_WIDTH-1:0] = factor_id;
			default:						rd_dat = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (bus_cyc)
		begin
			rd_dat_q <= rd_dat;
		end
	end

	assign rsp_o     = '{dat: rd_dat_q, ack: ack_q};
	assign cpu_irq_o = irq_q;

endmodule

/* source/peri_decoder.sv */
// --------------------
//  peripheral address decoder
//  strobe routing and response mux
//  unmapped accesses answered here
// --------------------

`timescale 1ns/1ps

module peri_decoder
	(
		// from the bridge
		input	wb_pkg::wb_req_t	req_i,
		output	wb_pkg::wb_rsp_t	rsp_o,

		// slaves
		output	wb_pkg::wb_req_t	irc_req_o,
		input	wb_pkg::wb_rsp_t	irc_rsp_i,
		output	wb_pkg::wb_req_t	timer_req_o,
		input	wb_pkg::wb_rsp_t	timer_rsp_i,
		output	wb_pkg::wb_req_t	sram_req_o,
		input	wb_pkg::wb_rsp_t	sram_rsp_i
	);

	logic	[peri_pkg::PERI_BASE_WIDTH-1:0]	base;
	peri_pkg::peri_sel_t					sel;

	// byte address bits 31:24
	assign base = req_i.adr[wb_pkg::WB_ADR_WIDTH-1 -: peri_pkg::PERI_BASE_WIDTH];

	always_comb
	begin
		case (base)
			peri_pkg::PERI_IRC_BASE:	sel = peri_pkg::SEL_IRC;
			peri_pkg::PERI_TIMER_BASE:	sel = peri_pkg::SEL_TIMER;
			peri_pkg::PERI_SRAM_BASE:	sel = peri_pkg::SEL_SRAM;
			default:					sel = peri_pkg::SEL_NONE;
		endcase
	end

	// --------------------
	//  request side
	// --------------------

	// shared fields, stb only where selected
	always_comb
	begin
		irc_req_o   = req_i;
		timer_req_o = req_i;
		sram_req_o  = req_i;

		irc_req_o.stb   = req_i.stb & (sel == peri_pkg::SEL_IRC);
		timer_req_o.stb = req_i.stb & (sel == peri_pkg::SEL_TIMER);
		sram_req_o.stb  = req_i.stb & (sel == peri_pkg::SEL_SRAM);
	end

	// --------------------
	//  response side
	// --------------------

	always_comb
	begin
		case (sel)
			peri_pkg::SEL_IRC:		rsp_o = irc_rsp_i;
			peri_pkg::SEL_TIMER:	rsp_o = timer_rsp_i;
			peri_pkg::SEL_SRAM:		rsp_o = sram_rsp_i;
			default:
			begin
				// nothing there, zero data and ack right away
				rsp_o.dat = '0;
				rsp_o.ack = req_i.stb;
			end
		endcase
	end

endmodule

/* source/wb_bridge.sv */
// --------------------
//  registered wishbone bridge
//  one access in flight
// --------------------

`timescale 1ns/1ps

module wb_bridge
	(
		input	logic				clk,
		input	logic				arst_n_i,

		// upstream, cpu side
		input	wb_pkg::wb_req_t	in_req_i,
		output	wb_pkg::wb_rsp_t	in_rsp_o,

		// downstream, peripheral side
		output	wb_pkg::wb_req_t	out_req_o,
		input	wb_pkg::wb_rsp_t	out_rsp_i
	);

	typedef enum logic {
		BR_IDLE,
		BR_BUSY
	} br_state_t;

	br_state_t							state_q;
	wb_pkg::wb_req_t					req_q;
	logic	[wb_pkg::WB_DAT_WIDTH-1:0]	rsp_dat_q;
	logic								rsp_ack_q;
	logic								accept;
	logic								done;

	// skip the cycle of our own ack, the cpu still holds stb there
	assign accept = (state_q == BR_IDLE) & in_req_i.stb & ~rsp_ack_q;
	assign done   = (state_q == BR_BUSY) & out_rsp_i.ack;

	// --------------------
	//  control
	// --------------------

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q   <= BR_IDLE;
			rsp_ack_q <= 1'b0;
		end
		else
		begin
			rsp_ack_q <= done;
			if (accept)
			begin
				state_q <= BR_BUSY;
			end
			else if (done)
			begin
				state_q <= BR_IDLE;
			end
		end
	end

	// request and read data
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_q <= in_req_i;
		end
		if (done)
		begin
			rsp_dat_q <= out_rsp_i.dat;
		end
	end

	// held fields, stb for as long as we are busy
	always_comb
	begin
		out_req_o     = req_q;
		out_req_o.stb = (state_q == BR_BUSY);
	end

	assign in_rsp_o = '{dat: rsp_dat_q, ack: rsp_ack_q};

endmodule

/* common/peri_pkg.sv */
// --------------------
//  peripheral address map
//  irc and timer register offsets
//  interrupt factor types
// --------------------

package peri_pkg;

	// top address byte of each slave
	localparam int			PERI_BASE_WIDTH = 8;
	localparam logic [7:0]	PERI_IRC_BASE   = 8'hf0;
	localparam logic [7:0]	PERI_TIMER_BASE = 8'hf1;
	localparam logic [7:0]	PERI_SRAM_BASE  = 8'hf2;

	localparam int SRAM_WORDS_DEFAULT = 256;

	// --------------------
	//  interrupt factors
	// --------------------

	// factor 0 timer, 1 and 2 external lines
	localparam int IRC_FACTOR_NUM      = 3;
	localparam int IRC_FACTOR_ID_WIDTH = 2;

	typedef logic [IRC_FACTOR_NUM-1:0]		irc_factor_t;
	typedef logic [IRC_FACTOR_ID_WIDTH-1:0]	irc_id_t;

	// reported when nothing enabled is pending
	localparam irc_id_t IRC_FACTOR_ID_NONE = 2'd3;

	// --------------------
	//  register word offsets
	// --------------------

	localparam int REG_OFS_WIDTH = 2;

	localparam logic [REG_OFS_WIDTH-1:0] IRC_REG_ENABLE    = 2'd0;
	localparam logic [REG_OFS_WIDTH-1:0] IRC_REG_PENDING   = 2'd1;
	localparam logic [REG_OFS_WIDTH-1:0] IRC_REG_FACTOR_ID = 2'd2;

	localparam logic [REG_OFS_WIDTH-1:0] TIMER_REG_CONTROL = 2'd0;
	localparam logic [REG_OFS_WIDTH-1:0] TIMER_REG_COMPARE = 2'd1;
	localparam logic [REG_OFS_WIDTH-1:0] TIMER_REG_COUNTER = 2'd2;

	// decoder target
	typedef enum logic [1:0] {
		SEL_IRC,
		SEL_TIMER,
		SEL_SRAM,
		SEL_NONE
	} peri_sel_t;

endpackage

/* common/wb_pkg.sv */
// --------------------
//  wishbone bus widths
//  request and response bundles
//  byte merge helper for sel writes
// --------------------

package wb_pkg;

	// word address, byte address bits 31:2
	localparam int WB_ADR_WIDTH = 30;
	localparam int WB_DAT_WIDTH = 32;
	localparam int WB_SEL_WIDTH = WB_DAT_WIDTH / 8;

	// master to slave
	typedef struct packed {
		logic	[WB_ADR_WIDTH-1:0]	adr;
		logic	[WB_DAT_WIDTH-1:0]	dat;
		logic						we;
		logic	[WB_SEL_WIDTH-1:0]	sel;
		logic						stb;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic	[WB_DAT_WIDTH-1:0]	dat;
		logic						ack;
	} wb_rsp_t;

	// replace the bytes of old_dat picked by sel
	function automatic logic [WB_DAT_WIDTH-1:0] wb_byte_merge
		(
			input logic	[WB_DAT_WIDTH-1:0]	old_dat,
			input logic	[WB_DAT_WIDTH-1:0]	new_dat,
			input logic	[WB_SEL_WIDTH-1:0]	sel
		);
		logic	[WB_DAT_WIDTH-1:0]	res;
		res = old_dat;
		for (int i = 0; i < WB_SEL_WIDTH; i++)
		begin
			if (sel[i])
			begin
				res[i*8 +: 8] = new_dat[i*8 +: 8];
			end
		end
		return res;
	endfunction

endpackage
